// ==== src.f ====
+incdir+design
design/mem_pkg.sv
design/mtimer.sv
design/ram_port.sv
design/ram_arbiter.sv
design/mem_subsys.sv
verif/clk_gen.sv
verif/mem_subsys_props.sv
verif/tb_mem_subsys.sv

// ==== verif/tb_mem_subsys.sv ====
// memory subsystem testbench
// drives fetch and load/store, models RAM with random back-pressure

`include "mem_consts.svh"

module tb_mem_subsys;

  import mem_pkg::*;

  localparam logic [63:0] MTIME_ADDR    = `MEM_TIMER_BASE + `MEM_MTIME_OFS;
  localparam logic [63:0] MTIMECMP_ADDR = `MEM_TIMER_BASE + `MEM_MTIMECMP_OFS;

  logic       clk;
  logic       rst_n;
  mem_req_t   fetch_req = '0;
  mem_req_t   lsu_req   = '0;
  mem_rsp_t   ram_rsp   = '0;
  fetch_rsp_t o_fetch_rsp;
  mem_rsp_t   o_lsu_rsp;
  mem_req_t   o_ram_req;
  logic       o_timer_int;
  int         errors = 0;
  logic [63:0] store [logic [63:0]];
  int         delay;
  bit         armed;

  clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  mem_subsys mem_subsys_i (
    .clk(clk), .rst_n(rst_n),
    .i_fetch_req(fetch_req), .o_fetch_rsp(o_fetch_rsp),
    .i_lsu_req(lsu_req), .o_lsu_rsp(o_lsu_rsp),
    .o_ram_req(o_ram_req), .i_ram_rsp(ram_rsp),
    .o_timer_int(o_timer_int)
  );

  bind mem_subsys mem_subsys_props props_i (
    .clk(clk), .rst_n(rst_n),
    .i_fetch_req(i_fetch_req), .i_lsu_req(i_lsu_req),
    .o_ram_req(o_ram_req), .i_ram_rsp(i_ram_rsp),
    .o_fetch_rsp(o_fetch_rsp), .o_lsu_rsp(o_lsu_rsp),
    .o_timer_int(o_timer_int), .tmr_sel(tmr_sel)
  );

  // RAM word: upper half inverted address unless written before
  function automatic logic [63:0] model_word(input logic [63:0] addr);
    if (store.exists(addr)) begin
      return store[addr];
    end
    return {~addr[63:32], addr[31:0]};
  endfunction

  // RAM model, ready after 0 to 3 extra cycles
  always @(posedge clk) begin
    if (!rst_n) begin
      ram_rsp <= '0;
      armed = 1'b0;
    end else begin
      ram_rsp.ready <= 1'b0;
      if (o_ram_req.valid && !ram_rsp.ready) begin
        if (!armed) begin
          delay = $urandom_range(3, 0);
          armed = 1'b1;
        end
        if (delay == 0) begin
          ram_rsp.ready <= 1'b1;
          ram_rsp.rdata <= model_word(o_ram_req.addr);
          if (o_ram_req.wen) begin
            store[o_ram_req.addr] = o_ram_req.wdata;
          end
          armed = 1'b0;
        end else begin
          delay--;
        end
      end
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic lsu_access(input logic wen, input logic [63:0] addr,
                            input logic [63:0] wdata, input logic to_ram,
                            output logic [63:0] rdata);
    int n;
    @(posedge clk);
    lsu_req <= '{valid: 1'b1, wen: wen, addr: addr, wdata: wdata, size: MEM_DWORD};
    @(negedge clk);
    if (to_ram) begin
      for (n = 0; n < 20 && !o_ram_req.valid; n++) @(negedge clk);
      if (!o_ram_req.valid) begin
        errors++;
        $display("timeout waiting for RAM request valid");
      end
      check_value("o_ram_req.addr", o_ram_req.addr, addr);
      check_value("o_ram_req.wdata", o_ram_req.wdata, wdata);
      check_value("o_ram_req.wen", o_ram_req.wen, wen);
      check_value("o_ram_req.size", o_ram_req.size, MEM_DWORD);
    end
    for (n = 0; n < 20 && !o_lsu_rsp.ready; n++) @(negedge clk);
    if (!o_lsu_rsp.ready) begin
      errors++;
      $display("timeout waiting for load/store ready");
    end
    rdata = o_lsu_rsp.rdata;
    @(posedge clk);
    lsu_req.valid <= 1'b0;
  endtask

  task automatic fetch_access(input logic [63:0] addr);
    int n;
    logic [63:0] word;
    @(posedge clk);
    fetch_req <= '{valid: 1'b1, wen: 1'b0, addr: addr, wdata: '0, size: MEM_WORD};
    @(negedge clk);
    for (n = 0; n < 40 && !o_fetch_rsp.ready; n++) @(negedge clk);
    if (!o_fetch_rsp.ready) begin
      errors++;
      $display("timeout waiting for fetch ready");
    end
    word = model_word(addr);
    check_value("o_fetch_rsp.rdata", o_fetch_rsp.rdata,
                addr[2] ? word[63:32] : word[31:0]);
    @(posedge clk);
    fetch_req.valid <= 1'b0;
  endtask

  task automatic wait_timer_int(input logic level);
    int n;
    @(negedge clk);
    for (n = 0; n < 20 && o_timer_int !== level; n++) @(negedge clk);
    if (o_timer_int !== level) begin
      errors++;
      $display("timer interrupt did not reach level %0b", level);
    end
  endtask

  initial begin
    logic [63:0] addr;
    logic [63:0] data;
    logic [63:0] rd;
    logic [63:0] t0;
    int n;
    void'($urandom(32'h5a7d_fb54));
    for (n = 0; n < 20 && rst_n !== 1'b1; n++) @(negedge clk);
    if (rst_n !== 1'b1) begin
      errors++;
      $display("reset never released");
    end
    repeat (2) @(posedge clk);
    fetch_access(64'h1004);
    fetch_access(64'h1000);
    for (int i = 0; i < 8; i++) begin
      addr = {$urandom, $urandom} & 64'h0000_0000_00ff_fff8;
      data = {$urandom, $urandom};
      lsu_access(1'b1, addr, data, 1'b1, rd);
      lsu_access(1'b0, addr, '0, 1'b1, rd);
      check_value("o_lsu_rsp.rdata", rd, data);
      fetch_access(({$urandom, $urandom} & 64'h0000_0000_00ff_fffc));
    end
    // same-cycle requests, load/store must reach RAM first
    fork
      lsu_access(1'b0, 64'h2000, '0, 1'b1, rd);
      fetch_access(64'h3004);
    join
    lsu_access(1'b0, MTIME_ADDR, '0, 1'b0, t0);
    lsu_access(1'b0, MTIME_ADDR, '0, 1'b0, rd);
    assert (rd > t0) else begin
      errors++;
      $display("mtime did not increase between reads");
    end
    lsu_access(1'b1, MTIMECMP_ADDR, 64'h8, 1'b0, rd);
    wait_timer_int(1'b1);
    lsu_access(1'b1, MTIMECMP_ADDR, '1, 1'b0, rd);
    wait_timer_int(1'b0);
    repeat (4) @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verif/mem_subsys_props.sv ====
// memory subsystem properties
// RAM port protocol, timer latency and response ordering

module mem_subsys_props (
  input logic                clk,
  input logic                rst_n,
  input mem_pkg::mem_req_t   i_fetch_req,
  input mem_pkg::mem_req_t   i_lsu_req,
  input mem_pkg::mem_req_t   o_ram_req,
  input mem_pkg::mem_rsp_t   i_ram_rsp,
  input mem_pkg::fetch_rsp_t o_fetch_rsp,
  input mem_pkg::mem_rsp_t   o_lsu_rsp,
  input logic                o_timer_int,
  input logic                tmr_sel
);

  import mem_pkg::*;

  logic ram_xfer;

  assign ram_xfer = o_ram_req.valid && i_ram_rsp.ready;

  // outputs quiet in the cycle after reset
  reset_quiet: assert property (@(posedge clk) !rst_n |=>
      !o_ram_req.valid && !o_fetch_rsp.ready && !o_lsu_rsp.ready && !o_timer_int)
    else begin
      tb_mem_subsys.errors++;
      $error("outputs active after reset");
    end

  ram_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      o_ram_req.valid && !i_ram_rsp.ready |=> o_ram_req.valid && $stable(o_ram_req))
    else begin
      tb_mem_subsys.errors++;
      $error("RAM request changed while stalled");
    end

  ram_valid_drops: assert property (@(posedge clk) disable iff (!rst_n)
      ram_xfer |=> !o_ram_req.valid)
    else begin
      tb_mem_subsys.errors++;
      $error("RAM valid held after ready");
    end

  fetch_after_ram: assert property (@(posedge clk) disable iff (!rst_n)
      o_fetch_rsp.ready |-> $past(ram_xfer))
    else begin
      tb_mem_subsys.errors++;
      $error("fetch ready without RAM ready");
    end

  lsu_after_source: assert property (@(posedge clk) disable iff (!rst_n)
      o_lsu_rsp.ready |-> $past(ram_xfer) || $past(tmr_sel))
    else begin
      tb_mem_subsys.errors++;
      $error("load/store ready without a source");
    end

  // timer answers one cycle later and never touches RAM
  timer_latency: assert property (@(posedge clk) disable iff (!rst_n)
      tmr_sel |-> !o_ram_req.valid ##1 (o_lsu_rsp.ready && !o_ram_req.valid))
    else begin
      tb_mem_subsys.errors++;
      $error("timer access latency or RAM use wrong");
    end

  // ready only goes to a requester still holding its request
  fetch_ready_owned: assert property (@(posedge clk) disable iff (!rst_n)
      o_fetch_rsp.ready |-> i_fetch_req.valid)
    else begin
      tb_mem_subsys.errors++;
      $error("fetch ready without a pending fetch request");
    end

  lsu_ready_owned: assert property (@(posedge clk) disable iff (!rst_n)
      o_lsu_rsp.ready |-> i_lsu_req.valid)
    else begin
      tb_mem_subsys.errors++;
      $error("load/store ready without a pending load/store request");
    end

endmodule

// ==== verif/clk_gen.sv ====
// testbench clock and reset
// period 40, rst_n held low for the first 5 cycles

module clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== design/mem_subsys.sv ====
// memory subsystem top
// fetch and load/store share one RAM port, timer window served locally

`include "mem_consts.svh"

module mem_subsys (
  input  logic                clk,
  input  logic                rst_n,
  input  mem_pkg::mem_req_t   i_fetch_req,
  output mem_pkg::fetch_rsp_t o_fetch_rsp,
  input  mem_pkg::mem_req_t   i_lsu_req,
  output mem_pkg::mem_rsp_t   o_lsu_rsp,
  output mem_pkg::mem_req_t   o_ram_req,
  input  mem_pkg::mem_rsp_t   i_ram_rsp,
  output logic                o_timer_int
);

  logic                 port_start;
  mem_pkg::mem_req_t    port_req;
  logic                 port_done;
  logic [`MEM_XLEN-1:0] port_rdata;

  logic                 tmr_sel;
  logic                 tmr_wen;
  logic [15:0]          tmr_ofs;
  logic [`MEM_XLEN-1:0] tmr_wdata;
  logic [`MEM_XLEN-1:0] tmr_rdata;

  ram_arbiter u_ram_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_fetch_req  (i_fetch_req),
    .o_fetch_rsp  (o_fetch_rsp),
    .i_lsu_req    (i_lsu_req),
    .o_lsu_rsp    (o_lsu_rsp),
    .o_port_start (port_start),
    .o_port_req   (port_req),
    .i_port_done  (port_done),
    .i_port_rdata (port_rdata),
    .o_tmr_sel    (tmr_sel),
    .o_tmr_wen    (tmr_wen),
    .o_tmr_ofs    (tmr_ofs),
    .o_tmr_wdata  (tmr_wdata),
    .i_tmr_rdata  (tmr_rdata)
  );

  ram_port u_ram_port (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_start   (port_start),
    .i_req     (port_req),
    .o_done    (port_done),
    .o_rdata   (port_rdata),
    .o_ram_req (o_ram_req),
    .i_ram_rsp (i_ram_rsp)
  );

  mtimer u_mtimer (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_sel       (tmr_sel),
    .i_wen       (tmr_wen),
    .i_ofs       (tmr_ofs),
    .i_wdata     (tmr_wdata),
    .o_rdata     (tmr_rdata),
    .o_timer_int (o_timer_int)
  );

endmodule

// ==== design/ram_arbiter.sv ====
// RAM arbiter
// grants load/store ahead of fetch, decodes the timer window, routes responses

`include "mem_consts.svh"

module ram_arbiter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mem_pkg::mem_req_t    i_fetch_req,
  output mem_pkg::fetch_rsp_t  o_fetch_rsp,
  input  mem_pkg::mem_req_t    i_lsu_req,
  output mem_pkg::mem_rsp_t    o_lsu_rsp,
  output logic                 o_port_start,
  output mem_pkg::mem_req_t    o_port_req,
  input  logic                 i_port_done,
  input  logic [`MEM_XLEN-1:0] i_port_rdata,
  output logic                 o_tmr_sel,
  output logic                 o_tmr_wen,
  output logic [15:0]          o_tmr_ofs,
  output logic [`MEM_XLEN-1:0] o_tmr_wdata,
  input  logic [`MEM_XLEN-1:0] i_tmr_rdata
);

  import mem_pkg::*;

  arb_state_e           state_q;
  arb_state_e           state_d;
  logic                 tmr_hit;
  logic                 idle;
  logic [`MEM_XLEN-1:0] tmr_rdata_q;

  assign idle    = (state_q == ARB_IDLE);
  assign tmr_hit = ((i_lsu_req.addr & `MEM_TIMER_MASK) == `MEM_TIMER_BASE);

  // timer access completes in the idle cycle itself
  assign o_tmr_sel   = idle && i_lsu_req.valid && tmr_hit;
  // narrow writes to the timer are acknowledged but dropped
  assign o_tmr_wen   = i_lsu_req.wen && (i_lsu_req.size == MEM_DWORD);
  assign o_tmr_ofs   = i_lsu_req.addr[15:0];
  assign o_tmr_wdata = i_lsu_req.wdata;

  // load/store wins over fetch
  assign o_port_start = idle && ((i_lsu_req.valid && !tmr_hit) ||
                                 (!i_lsu_req.valid && i_fetch_req.valid));
  assign o_port_req   = i_lsu_req.valid ? i_lsu_req : i_fetch_req;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ARB_IDLE: begin
        if (i_lsu_req.valid) begin
          state_d = tmr_hit ? ARB_TIMER : ARB_LSU;
        end else if (i_fetch_req.valid) begin
          state_d = ARB_FETCH;
        end
      end
      ARB_FETCH, ARB_LSU: begin
        if (i_port_done) begin
          state_d = ARB_IDLE;
        end
      end
      default: begin
        state_d = ARB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ARB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (o_tmr_sel) begin
      tmr_rdata_q <= i_tmr_rdata;
    end
  end

  always_comb begin
    o_lsu_rsp.ready = (state_q == ARB_TIMER) || ((state_q == ARB_LSU) && i_port_done);
    o_lsu_rsp.rdata = (state_q == ARB_TIMER) ? tmr_rdata_q : i_port_rdata;
  end

  // addr bit 2 picks the instruction half, request still held by fetch
  always_comb begin
    o_fetch_rsp.ready = (state_q == ARB_FETCH) && i_port_done;
    o_fetch_rsp.rdata = i_fetch_req.addr[2] ? i_port_rdata[`MEM_XLEN-1:`MEM_INSTR_W]
                                            : i_port_rdata[`MEM_INSTR_W-1:0];
  end

endmodule

// ==== design/ram_port.sv ====
// RAM request port
// holds one granted request on the external bus until RAM answers

`include "mem_consts.svh"

module ram_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 i_start,
  input  mem_pkg::mem_req_t    i_req,
  output logic                 o_done,
  output logic [`MEM_XLEN-1:0] o_rdata,
  output mem_pkg::mem_req_t    o_ram_req,
  input  mem_pkg::mem_rsp_t    i_ram_rsp
);

  import mem_pkg::*;

  mem_req_t             req_q;
  logic                 valid_q;
  logic                 done_q;
  logic [`MEM_XLEN-1:0] rdata_q;
  logic                 xfer;

  // transfer completes on the ready cycle
  assign xfer = valid_q && i_ram_rsp.ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      if (i_start) begin
        valid_q <= 1'b1;
      end else if (xfer) begin
        valid_q <= 1'b0;
      end
      done_q <= xfer;
    end
  end

  always_ff @(posedge clk) begin
    if (i_start) begin
      req_q <= i_req;
    end
    if (xfer) begin
      rdata_q <= i_ram_rsp.rdata;
    end
  end

  always_comb begin
    o_ram_req       = req_q;
    o_ram_req.valid = valid_q;
  end

  assign o_done  = done_q;
  assign o_rdata = rdata_q;

endmodule

// ==== design/mtimer.sv ====
// machine timer
// free running mtime, writable mtimecmp, level interrupt when mtime >= mtimecmp

`include "mem_consts.svh"

module mtimer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 i_sel,
  input  logic                 i_wen,
  input  logic [15:0]          i_ofs,
  input  logic [`MEM_XLEN-1:0] i_wdata,
  output logic [`MEM_XLEN-1:0] o_rdata,
  output logic                 o_timer_int
);

  logic [`MEM_XLEN-1:0] mtime_q;
  logic [`MEM_XLEN-1:0] mtimecmp_q;
  logic                 int_q;
  logic                 wr_mtime;
  logic                 wr_mtimecmp;

  assign wr_mtime    = i_sel && i_wen && (i_ofs == `MEM_MTIME_OFS);
  assign wr_mtimecmp = i_sel && i_wen && (i_ofs == `MEM_MTIMECMP_OFS);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      int_q      <= 1'b0;
    end else begin
      // a write replaces this cycle's increment
      if (wr_mtime) begin
        mtime_q <= i_wdata;
      end else begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_mtimecmp) begin
        mtimecmp_q <= i_wdata;
      end
      int_q <= (mtime_q >= mtimecmp_q);
    end
  end

  // unmapped offsets read as zero
  always_comb begin
    o_rdata = '0;
    if (i_sel) begin
      case (i_ofs)
        `MEM_MTIME_OFS:    o_rdata = mtime_q;
        `MEM_MTIMECMP_OFS: o_rdata = mtimecmp_q;
        default:           o_rdata = '0;
      endcase
    end
  end

  assign o_timer_int = int_q;

endmodule

// ==== design/mem_pkg.sv ====
// memory subsystem types
// request and response bundles plus size and arbiter state encodings

`include "mem_consts.svh"

package mem_pkg;

  typedef enum logic [1:0] {
    MEM_BYTE  = 2'd0,
    MEM_HALF  = 2'd1,
    MEM_WORD  = 2'd2,
    MEM_DWORD = 2'd3
  } mem_size_e;

  typedef enum logic [1:0] {
    ARB_IDLE  = 2'd0,
    ARB_FETCH = 2'd1,
    ARB_LSU   = 2'd2,
    ARB_TIMER = 2'd3
  } arb_state_e;

  typedef struct packed {
    logic                   valid;
    logic                   wen;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_XLEN-1:0]   wdata;
    mem_size_e              size;
  } mem_req_t;

  typedef struct packed {
    logic                 ready;
    logic [`MEM_XLEN-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic                    ready;
    logic [`MEM_INSTR_W-1:0] rdata;
  } fetch_rsp_t;

endpackage

// ==== design/mem_consts.svh ====
// memory subsystem constants
// data widths and the fixed machine timer address map

`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

`define MEM_XLEN          64
`define MEM_ADDR_W        64
`define MEM_INSTR_W       32

// 64 KiB timer window
`define MEM_TIMER_BASE    64'h0000_0000_0200_0000
`define MEM_TIMER_MASK    64'hffff_ffff_ffff_0000

// register offsets inside the window
`define MEM_MTIMECMP_OFS  16'h4000
`define MEM_MTIME_OFS     16'hbff8

`endif
